// File: hawk_pkg.sv
/* shared widths, address map and packet types of the page-read manager.
   entries are 8 bytes; ATT ids start at 1 so id 0 is never read.
   free-list index 0 (lst_null) marks an empty list */
package hawk_pkg;

  localparam int addr_w      = 40;  // AXI address
  localparam int data_w      = 64;  // AXI data, one entry per beat
  localparam int ppn_w       = 28;  // host or physical page number
  localparam int idx_w       = 12;  // ATT id and free-list index
  localparam int entry_bytes = 8;
  localparam int page_shift  = 12;  // 4 KiB pages

  localparam logic [addr_w-1:0] att_base  = 40'h00_c000_0000; // ATT entry 0
  localparam logic [addr_w-1:0] tol_base  = 40'h00_c010_0000; // free-list entry 0
  localparam logic [ppn_w-1:0]  hppn_base = 28'h008_0000;     // first host page in ATT
  localparam logic [idx_w-1:0]  lst_null  = '0;

  typedef enum logic [1:0] {
    sts_dalloc = 2'd0,  // no physical page yet
    sts_uncomp = 2'd1,
    sts_comp   = 2'd2,  // needs decompression, not handled here
    sts_incomp = 2'd3   // stored raw, compression failed earlier
  } page_sts_t;

  typedef enum logic [1:0] {
    cause_none       = 2'd0,
    cause_bus_error  = 2'd1,
    cause_comp_page  = 2'd2,
    cause_list_empty = 2'd3
  } halt_cause_t;

  typedef struct packed {
    logic             lookup;  // one-cycle strobe
    logic [ppn_w-1:0] hppn;
  } lkup_req_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              arvalid;
    logic              rready;
  } rd_req_t;

  typedef struct packed {
    logic              arready;
    logic              rvalid;
    logic              rlast;
    logic [1:0]        rresp;  // nonzero is an error
    logic [data_w-1:0] rdata;
  } rd_rsp_t;

  typedef struct packed {
    logic              allow_access;  // one-cycle strobe
    logic [addr_w-1:0] ppa;
    page_sts_t         sts;
  } trnsl_rsp_t;

  typedef struct packed {
    logic             tbl_update;     // one-cycle strobe to page-write manager
    logic [idx_w-1:0] att_id;
    logic [ppn_w-1:0] way;
    page_sts_t        sts;
    logic [idx_w-1:0] new_free_head;
  } tbl_upd_t;

  typedef struct packed {
    page_sts_t        sts;
    logic [ppn_w-1:0] ppn;
  } att_entry_t;

  typedef struct packed {
    logic [ppn_w-1:0] way;
    logic [idx_w-1:0] next;
  } lst_entry_t;

  typedef struct packed {
    logic        ready;
    logic        halted;  // sticky until reset
    halt_cause_t cause;
  } pgrd_status_t;

endpackage

// File: hawk_rd_port.sv
/* single-beat AXI read master, one request in flight.
   start is ignored while a read is pending; rready is tied high */
`timescale 1ns/1ps

module hawk_rd_port
  import hawk_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start,
  input  logic [addr_w-1:0] addr,
  output rd_req_t           rd_req,
  input  rd_rsp_t           rd_rsp,
  output logic              done,
  output logic              err,
  output logic [data_w-1:0] rdata
);

  logic              arvalid_q;  // request on the address channel
  logic              wait_q;     // address taken, waiting for the beat
  logic              done_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] rdata_q;
  logic              err_q;
  logic              busy;
  logic              beat;

  assign busy = arvalid_q | wait_q;
  assign beat = wait_q & rd_rsp.rvalid & rd_rsp.rlast;  // single beat, so last is the only one

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arvalid_q <= 1'b0;
      wait_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= beat;                               // pulse one cycle after the beat
      if (start && !busy) arvalid_q <= 1'b1;
      else if (arvalid_q && rd_rsp.arready) begin   // hold until accepted
        arvalid_q <= 1'b0;
        wait_q    <= 1'b1;
      end else if (beat) wait_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start && !busy) addr_q <= addr;  // stays stable while arvalid is high
    if (beat) begin
      rdata_q <= rd_rsp.rdata;
      err_q   <= |rd_rsp.rresp;          // SLVERR or DECERR
    end
  end

  assign rd_req = '{addr: addr_q, arvalid: arvalid_q, rready: 1'b1};
  assign done   = done_q;
  assign err    = err_q;
  assign rdata  = rdata_q;

endmodule

// File: hawk_entry_codec.sv
/* combinational entry address math and decode.
   hppn below hppn_base wraps; the caller is expected to stay in range */
`timescale 1ns/1ps

module hawk_entry_codec
  import hawk_pkg::*;
(
  input  logic [ppn_w-1:0]  hppn,
  input  logic [idx_w-1:0]  free_head,
  input  logic [data_w-1:0] raw,
  output logic [idx_w-1:0]  att_id,
  output logic [addr_w-1:0] att_addr,
  output logic [addr_w-1:0] lst_addr,
  output att_entry_t        att_entry,
  output lst_entry_t        lst_entry
);

  logic [ppn_w-1:0] way;  // same field in both entry kinds

  // ids start at 1, entry 0 of the table is never used
  assign att_id = idx_w'(hppn - hppn_base + ppn_w'(1));

  assign att_addr = att_base + addr_w'(att_id) * addr_w'(entry_bytes);
  assign lst_addr = tol_base + addr_w'(free_head) * addr_w'(entry_bytes);

  assign way = raw[page_shift +: ppn_w];

  always_comb begin
    att_entry.sts  = page_sts_t'(raw[1:0]);  // status in the low bits
    att_entry.ppn  = way;
    lst_entry.way  = way;
    lst_entry.next = raw[data_w-1 -: idx_w]; // next free index in the top bits
  end

endmodule

// File: hawk_pgrd_fsm.sv
/* lookup sequencer, one lookup at a time. compressed pages, an empty
   free list and read errors halt the FSM until rst_ni.
   free_head must stay stable from check_att until the list read starts */
`timescale 1ns/1ps

module hawk_pgrd_fsm
  import hawk_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lkup_req_t         lkup_req,
  input  logic [idx_w-1:0]  free_head,
  input  logic [addr_w-1:0] att_addr,
  input  logic [addr_w-1:0] lst_addr,
  input  logic [idx_w-1:0]  att_id,
  input  att_entry_t        att_entry,
  input  lst_entry_t        lst_entry,
  output logic              rd_start,
  output logic [addr_w-1:0] rd_addr,
  input  logic              rd_done,
  input  logic              rd_err,
  input  logic              pgwr_ready,
  input  logic              tbl_update_done,
  output trnsl_rsp_t        trnsl_rsp,
  output tbl_upd_t          tbl_upd,
  output logic [ppn_w-1:0]  hppn,
  output pgrd_status_t      status
);

  typedef enum logic [3:0] {
    st_idle, st_read_att, st_decode_att, st_check_att, st_read_lst,
    st_allocate, st_tbl_update, st_tbl_wait, st_halt
  } state_t;

  state_t            state_q, state_d;
  halt_cause_t       cause_q, cause_d;
  logic              rd_start_q;
  logic [addr_w-1:0] rd_addr_q;
  logic [ppn_w-1:0]  hppn_q;
  logic [idx_w-1:0]  att_id_q;
  att_entry_t        att_q;    // ATT entry, or the freshly allocated page
  lst_entry_t        lst_q;    // popped free-list head
  logic              hit;
  logic              ready;
  logic              accept;
  logic              lst_go;

  // check_att answers at once for a page that is already mapped
  assign hit = (state_q == st_check_att) &&
               (att_q.sts == sts_uncomp || att_q.sts == sts_incomp);
  assign ready  = (state_q == st_idle) || hit;  // rises with allow_access
  assign accept = lkup_req.lookup && ready;     // lookups while busy are dropped
  assign lst_go = (state_q == st_check_att) && (state_d == st_read_lst);

  // codec sees the new hppn in the accept cycle, so att_id/att_addr are valid there
  assign hppn = accept ? lkup_req.hppn : hppn_q;

  always_comb begin
    state_d = state_q;
    cause_d = cause_q;
    case (state_q)
      st_idle: if (accept) state_d = st_read_att;
      st_read_att: begin
        if (rd_done) begin
          if (rd_err) begin
            state_d = st_halt;
            cause_d = cause_bus_error;
          end else state_d = st_decode_att;
        end
      end
      st_decode_att: state_d = st_check_att;  // entry latched this cycle
      st_check_att: begin
        if (hit) state_d = accept ? st_read_att : st_idle;  // back-to-back lookup
        else if (att_q.sts == sts_comp) begin
          state_d = st_halt;                  // decompression not supported
          cause_d = cause_comp_page;
        end else if (free_head == lst_null) begin
          state_d = st_halt;                  // no free way to give out
          cause_d = cause_list_empty;
        end else state_d = st_read_lst;       // deallocated, pop the free list
      end
      st_read_lst: begin
        if (rd_done) begin
          if (rd_err) begin
            state_d = st_halt;
            cause_d = cause_bus_error;
          end else state_d = st_allocate;
        end
      end
      st_allocate:   state_d = st_tbl_update;
      st_tbl_update: if (pgwr_ready) state_d = st_tbl_wait;
      st_tbl_wait:   if (tbl_update_done) state_d = st_check_att; // answers as a hit
      st_halt:       state_d = st_halt;       // only reset leaves
      default:       state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      cause_q    <= cause_none;
      rd_start_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cause_q    <= cause_d;
      rd_start_q <= accept || lst_go;  // read starts the cycle after the decision
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hppn_q    <= lkup_req.hppn;
      att_id_q  <= att_id;
      rd_addr_q <= att_addr;
    end
    if (lst_go) rd_addr_q <= lst_addr;
    if (state_q == st_decode_att) att_q <= att_entry;
    if (state_q == st_allocate) lst_q <= lst_entry;
    if (state_q == st_tbl_wait && tbl_update_done) begin
      att_q.sts <= sts_uncomp;       // page now mapped to the popped way
      att_q.ppn <= lst_q.way;
    end
  end

  assign rd_start = rd_start_q;
  assign rd_addr  = rd_addr_q;

  assign trnsl_rsp.allow_access = hit;
  assign trnsl_rsp.ppa          = addr_w'(att_q.ppn) << page_shift;
  assign trnsl_rsp.sts          = att_q.sts;

  // update waits for the page-write manager, pulse lasts one cycle
  assign tbl_upd.tbl_update    = (state_q == st_tbl_update) && pgwr_ready;
  assign tbl_upd.att_id        = att_id_q;
  assign tbl_upd.way           = lst_q.way;
  assign tbl_upd.sts           = sts_uncomp;
  assign tbl_upd.new_free_head = lst_q.next;

  assign status.ready  = ready;
  assign status.halted = (state_q == st_halt);
  assign status.cause  = cause_q;

endmodule

// File: hawk_pgrd_mngr.sv
/* page-read manager top, address-translation read path only.
   one lookup at a time; status.halted needs rst_ni to clear */
`timescale 1ns/1ps

module hawk_pgrd_mngr
  import hawk_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  lkup_req_t        lkup_req,
  input  logic [idx_w-1:0] free_head,
  output rd_req_t          rd_req,
  input  rd_rsp_t          rd_rsp,
  input  logic             pgwr_ready,
  input  logic             tbl_update_done,
  output trnsl_rsp_t       trnsl_rsp,
  output tbl_upd_t         tbl_upd,
  output pgrd_status_t     status
);

  logic [ppn_w-1:0]  hppn;
  logic [idx_w-1:0]  att_id;
  logic [addr_w-1:0] att_addr, lst_addr;
  att_entry_t        att_entry;
  lst_entry_t        lst_entry;
  logic              rd_start, rd_done, rd_err;
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_data;   // last captured entry, feeds the decoder

  hawk_pgrd_fsm u_fsm (
    .clk_i, .rst_ni, .lkup_req, .free_head, .att_addr, .lst_addr, .att_id,
    .att_entry, .lst_entry, .rd_start, .rd_addr, .rd_done, .rd_err,
    .pgwr_ready, .tbl_update_done, .trnsl_rsp, .tbl_upd, .hppn, .status
  );

  hawk_entry_codec u_codec (
    .hppn, .free_head, .raw(rd_data), .att_id, .att_addr, .lst_addr,
    .att_entry, .lst_entry
  );

  hawk_rd_port u_rd_port (
    .clk_i, .rst_ni, .start(rd_start), .addr(rd_addr), .rd_req, .rd_rsp,
    .done(rd_done), .err(rd_err), .rdata(rd_data)
  );

endmodule

// File: hawk_pgrd_properties.sv
/* bound into hawk_pgrd_mngr, reports through $error only.
   all checks are off while rst_ni is low */
`timescale 1ns/1ps

module hawk_pgrd_properties
  import hawk_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input rd_req_t      rd_req,
  input rd_rsp_t      rd_rsp,
  input trnsl_rsp_t   trnsl_rsp,
  input tbl_upd_t     tbl_upd,
  input pgrd_status_t status
);

  // request held with a stable address until the slave takes it
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req.arvalid && !rd_rsp.arready |=> rd_req.arvalid && $stable(rd_req.addr))
    else $error("arvalid or addr changed before arready");

  a_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(trnsl_rsp.allow_access && tbl_upd.tbl_update))
    else $error("allow_access and tbl_update high together");

  a_halt_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rd_req.arvalid) |-> !status.halted)
    else $error("new read request while halted");

  a_acc_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trnsl_rsp.allow_access |-> status.ready)  // ready rises with the answer
    else $error("allow_access without ready");

endmodule

bind hawk_pgrd_mngr hawk_pgrd_properties u_props (.*);

// File: hawk_pgrd_tb.sv
/* drives inputs 1 ns after the rising edge and samples at the falling edge.
   memory and page-write responders run on their own; rows are checked in order */
`timescale 1ns/1ps

module hawk_pgrd_tb
  import hawk_pkg::*;
;

  localparam logic [1:0] k_hit = 2'd0, k_alloc = 2'd1, k_halt = 2'd2;

  typedef struct packed {
    logic [ppn_w-1:0] hppn;
    page_sts_t        sts;
    logic [ppn_w-1:0] ppn;
    logic [idx_w-1:0] fh;    // free head at lookup
    logic [ppn_w-1:0] way;   // list head entry
    logic [idx_w-1:0] next;
    logic             err;   // answer reads with SLVERR
    logic [1:0]       kind;
    halt_cause_t      cause;
  } row_t;

  logic clk_i, rst_ni, pgwr_ready, tbl_update_done;
  lkup_req_t lkup_req;
  logic [idx_w-1:0] free_head;
  rd_req_t rd_req;
  rd_rsp_t rd_rsp;
  trnsl_rsp_t trnsl_rsp;
  tbl_upd_t tbl_upd;
  pgrd_status_t status;

  row_t rows [8];
  row_t cur;
  logic [addr_w-1:0] rd_addrs [$];  // accepted read addresses of the row
  int n_acc, n_upd, err_cnt;
  trnsl_rsp_t acc_rsp;
  tbl_upd_t upd_pkt;
  logic done_seen, acc_after_done;

  hawk_pgrd_mngr dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0d ns %s: got %h expected %h", $time, what, got, exp);
      stop_run("first mismatch");
    end
  endtask

  // outputs seen each cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check("rready", 64'(rd_req.rready), 64'd1);  // beat always taken
      if (rd_req.arvalid && rd_rsp.arready) rd_addrs.push_back(rd_req.addr);
      if (trnsl_rsp.allow_access) begin
        n_acc++;
        acc_rsp = trnsl_rsp;
        acc_after_done = done_seen;
      end
      if (tbl_upd.tbl_update) begin
        n_upd++;
        upd_pkt = tbl_upd;
      end
    end
  end

  // memory: random arready delay, one beat 1..4 cycles after acceptance
  initial begin : mem_responder
    int unsigned dly;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] raw;
    forever begin
      @(negedge clk_i);
      if (rst_ni && rd_req.arvalid) begin
        dly = $urandom % 6;
        repeat (dly) @(posedge clk_i);
        @(posedge clk_i);
        #1 rd_rsp.arready = 1'b1;
        @(negedge clk_i);
        a = rd_req.addr;
        @(posedge clk_i);
        #1 rd_rsp.arready = 1'b0;
        raw = '0;
        if (a == att_base + (addr_w'(idx_w'(cur.hppn - hppn_base + 28'd1)) << 3)) begin
          raw[page_shift +: ppn_w] = cur.ppn;
          raw[1:0] = cur.sts;
        end else if (a == tol_base + (addr_w'(cur.fh) << 3)) begin
          raw[page_shift +: ppn_w] = cur.way;
          raw[data_w-1 -: idx_w] = cur.next;
        end else stop_run("read address matches neither ATT nor free list");
        dly = $urandom % 4;
        repeat (dly) @(posedge clk_i);
        #1 rd_rsp.rvalid = 1'b1;
        rd_rsp.rlast = 1'b1;
        rd_rsp.rresp = cur.err ? 2'b10 : 2'b00;
        rd_rsp.rdata = raw;
        @(posedge clk_i);
        #1 rd_rsp.rvalid = 1'b0;
        rd_rsp.rlast = 1'b0;
      end
    end
  end

  // page-write manager: done two cycles after the update, then moves the head
  initial begin : pgwr_responder
    logic [idx_w-1:0] nh;
    forever begin
      @(negedge clk_i);
      if (rst_ni && tbl_upd.tbl_update) begin
        nh = tbl_upd.new_free_head;
        repeat (2) @(posedge clk_i);
        #1 tbl_update_done = 1'b1;
        done_seen = 1'b1;
        free_head = nh;
        @(posedge clk_i);
        #1 tbl_update_done = 1'b0;
      end
    end
  end

  initial begin : pgwr_ready_gen
    int unsigned dly;
    forever begin
      dly = $urandom % 6;
      repeat (dly) begin
        @(posedge clk_i);
        #1 pgwr_ready = 1'b0;
      end
      @(posedge clk_i);
      #1 pgwr_ready = 1'b1;
    end
  end

  task automatic clear_row_log();
    rd_addrs.delete();
    n_acc = 0;
    n_upd = 0;
    done_seen = 1'b0;
    acc_after_done = 1'b0;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    clear_row_log();
    repeat (3) begin
      @(negedge clk_i);
      check("ready after reset", 64'(status.ready), 64'd1);
      check("halted after reset", 64'(status.halted), 64'd0);
      check("idle outputs after reset", 64'({rd_req.arvalid, trnsl_rsp.allow_access,
            tbl_upd.tbl_update}), 64'd0);
    end
    check("reads after reset", 64'(rd_addrs.size()), 64'd0);
  endtask

  task automatic pulse_lookup(input logic [ppn_w-1:0] hppn);
    @(posedge clk_i);
    #1 lkup_req = '{lookup: 1'b1, hppn: hppn};
    @(posedge clk_i);
    #1 lkup_req.lookup = 1'b0;
  endtask

  task automatic run_row(input int i);
    int t;
    logic [addr_w-1:0] exp_att, exp_lst;
    cur = rows[i];
    exp_att = att_base + (addr_w'(idx_w'(cur.hppn - hppn_base + 28'd1)) << 3);
    exp_lst = tol_base + (addr_w'(cur.fh) << 3);
    clear_row_log();
    @(posedge clk_i);
    #1 free_head = cur.fh;
    pulse_lookup(cur.hppn);
    for (t = 0; t < 400 && n_acc == 0 && !status.halted; t++) begin
      @(negedge clk_i);
      #1;
    end
    if (n_acc == 0 && !status.halted) stop_run("timeout waiting for allow_access or halt");
    repeat (6) @(negedge clk_i);
    check("ATT read address", 64'(rd_addrs[0]), 64'(exp_att));
    if (cur.kind == k_halt) begin
      check("halted", 64'(status.halted), 64'd1);
      check("halt cause", 64'(status.cause), 64'(cur.cause));
      check("reads before halt", 64'(rd_addrs.size()), 64'd1);
      pulse_lookup(cur.hppn);  // must be ignored
      repeat (20) @(negedge clk_i);
      check("ready while halted", 64'(status.ready), 64'd0);
      check("allow_access after halt", 64'(n_acc), 64'd0);
      check("reads after ignored lookup", 64'(rd_addrs.size()), 64'd1);
      apply_reset();
    end else if (cur.kind == k_alloc) begin
      check("reads on allocation", 64'(rd_addrs.size()), 64'd2);
      check("list read address", 64'(rd_addrs[1]), 64'(exp_lst));
      check("tbl_update count", 64'(n_upd), 64'd1);
      check("update att_id", 64'(upd_pkt.att_id), 64'(idx_w'(cur.hppn - hppn_base + 28'd1)));
      check("update way", 64'(upd_pkt.way), 64'(cur.way));
      check("update sts", 64'(upd_pkt.sts), 64'(sts_uncomp));
      check("update new head", 64'(upd_pkt.new_free_head), 64'(cur.next));
      check("allow_access count", 64'(n_acc), 64'd1);
      check("allocated ppa", 64'(acc_rsp.ppa), 64'(addr_w'(cur.way) << page_shift));
      check("allocated sts", 64'(acc_rsp.sts), 64'(sts_uncomp));
      check("answer after update done", 64'(acc_after_done), 64'd1);
    end else begin
      check("reads on hit", 64'(rd_addrs.size()), 64'd1);
      check("tbl_update on hit", 64'(n_upd), 64'd0);
      check("allow_access count", 64'(n_acc), 64'd1);
      check("hit ppa", 64'(acc_rsp.ppa), 64'(addr_w'(cur.ppn) << page_shift));
      check("hit sts", 64'(acc_rsp.sts), 64'(cur.sts));
    end
  endtask

  initial begin : main
    void'($urandom(32'h426f_4f3a));
    rst_ni = 1'b0;
    lkup_req = '0;
    free_head = '0;
    rd_rsp = '0;
    pgwr_ready = 1'b0;
    tbl_update_done = 1'b0;
    err_cnt = 0;
    //            hppn            sts         ppn         fh      way         next    err  kind
    rows[0] = '{hppn_base + 28'h5,   sts_uncomp, 28'h0012345, 12'h003, 28'h0, 12'h0, 1'b0, k_hit,
                cause_none};
    rows[1] = '{hppn_base + 28'h20,  sts_incomp, 28'h0abcdef, 12'h003, 28'h0, 12'h0, 1'b0, k_hit,
                cause_none};
    rows[2] = '{hppn_base + 28'h7,   sts_dalloc, 28'h0, 12'h005, 28'h0777001, 12'h009, 1'b0,
                k_alloc, cause_none};
    rows[3] = '{hppn_base + 28'h100, sts_dalloc, 28'h0, 12'h009, 28'h00fe0aa, 12'h000, 1'b0,
                k_alloc, cause_none};
    rows[4] = '{hppn_base + 28'h9,   sts_comp,   28'h0000777, 12'h004, 28'h0, 12'h0, 1'b0, k_halt,
                cause_comp_page};
    rows[5] = '{hppn_base + 28'h11,  sts_dalloc, 28'h0, 12'h000, 28'h0, 12'h0, 1'b0, k_halt,
                cause_list_empty};
    rows[6] = '{hppn_base + 28'h3,   sts_uncomp, 28'h0000abc, 12'h002, 28'h0, 12'h0, 1'b1, k_halt,
                cause_bus_error};
    rows[7] = '{hppn_base + 28'h3,   sts_uncomp, 28'h0000abc, 12'h002, 28'h0, 12'h0, 1'b0, k_hit,
                cause_none};
    apply_reset();
    for (int i = 0; i < 8; i++) run_row(i);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #2ms;
    stop_run("simulation ran past its time limit");
  end

endmodule

// File: verilog.f
hawk_pkg.sv
hawk_rd_port.sv
hawk_entry_codec.sv
hawk_pgrd_fsm.sv
hawk_pgrd_mngr.sv
hawk_pgrd_properties.sv
hawk_pgrd_tb.sv

// File: run.sh
#!/bin/sh
# build and run the page-read manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module hawk_pgrd_tb \
  -f verilog.f -o hawk_pgrd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/hawk_pgrd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
echo "pass message not found"
exit 1
